/* files.f */
red_op_pkg.sv
red_noc_pkg.sv
red_route_mask.sv
red_sync.sv
red_route_arb.sv
red_combine.sv
red_out_queue.sv
red_node_top.sv
tb_clk_gen.sv
tb_red_node.sv

/* red_combine.sv */
/*
 * Payload combine
 * Folds the joined payloads with the header's operation and holds the
 * result flit in one output register until the queue takes it
 */
`timescale 1ns/1ns

module red_combine #(
  parameter int unsigned PayloadW = 32
) (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  red_noc_pkg::flit_t [red_noc_pkg::NumRoutes-1:0] in_flit_i,
  input  logic               [red_noc_pkg::NumRoutes-1:0] join_mask_i,
  input  red_noc_pkg::route_e                             sel_i,
  input  logic                                            join_valid_i,
  output logic                                            join_ready_o,
  output red_noc_pkg::flit_t                              res_flit_o,
  output logic                                            res_valid_o,
  input  logic                                            res_ready_i
);

  red_noc_pkg::hdr_t    sel_hdr;
  red_op_pkg::payload_u acc;
  red_op_pkg::payload_u cur;

  logic [PayloadW-1:0]   ident;
  logic [PayloadW/2-1:0] lane_hi;
  logic [PayloadW/2-1:0] lane_lo;

  logic               join_fire;
  logic               res_valid_q;
  red_noc_pkg::flit_t res_flit_q;

  // Joins held off in reset and on the first cycle after it
  logic run_q;

  assign sel_hdr = in_flit_i[sel_i].hdr;

  // Neutral start value per operation
  always_comb begin
    case (sel_hdr.op)
      red_op_pkg::OpMax32:  ident = {1'b1, {(PayloadW-1){1'b0}}};
      red_op_pkg::OpMinU32: ident = '1;
      default:              ident = '0;
    endcase
  end

  // Fold over the joined routes
  always_comb begin
    acc.word = ident;
    cur.word = '0;
    lane_hi  = '0;
    lane_lo  = '0;
    for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
      cur = in_flit_i[r].payload;
      if (join_mask_i[r]) begin
        case (sel_hdr.op)
          red_op_pkg::OpAdd32: acc.word = acc.word + cur.word;
          // Signed compare
          red_op_pkg::OpMax32: begin
            if ($signed(cur.word) > $signed(acc.word)) begin
              acc.word = cur.word;
            end
          end
          red_op_pkg::OpMinU32: begin
            if (cur.word < acc.word) begin
              acc.word = cur.word;
            end
          end
          red_op_pkg::OpOr32: acc.word = acc.word | cur.word;
          // Lanes wrap on their own, no carry across
          red_op_pkg::OpAdd16x2: begin
            lane_hi        = acc.lanes.hi + cur.lanes.hi;
            lane_lo        = acc.lanes.lo + cur.lanes.lo;
            acc.lanes.hi   = lane_hi;
            acc.lanes.lo   = lane_lo;
          end
          default: acc.word = acc.word;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // Register free or emptying this cycle, once out of reset
  assign join_ready_o = run_q && (!res_valid_q || res_ready_i);
  assign join_fire    = join_valid_i && join_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_q <= 1'b0;
    end else if (join_fire) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // Result keeps the selected header
  always_ff @(posedge clk_i) begin
    if (join_fire) begin
      res_flit_q <= '{hdr: sel_hdr, payload: acc};
    end
  end

  assign res_flit_o  = res_flit_q;
  assign res_valid_o = res_valid_q;

endmodule

/* red_noc_pkg.sv */
/*
 * Network types of the reduction stage
 * Node coordinates, input route indices and the single-flit format
 * used on every route of the mesh node
 */
package red_noc_pkg;

  // Node coordinate in a 4x4 mesh
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } xy_id_t;

  // Four neighbours plus the local endpoint
  parameter int unsigned NumRoutes = 5;

  // Input route index
  // North neighbour sits at y + 1, East neighbour at x + 1
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_e;

  // Flit header, 15 bits
  typedef struct packed {
    // Root of the reduction tree
    xy_id_t          dst_id;
    // Group base coordinate
    xy_id_t          grp_id;
    // Set bits mean any value in that position
    xy_id_t          grp_mask;
    red_op_pkg::op_e op;
  } hdr_t;

  // Whole flit, 47 bits
  typedef struct packed {
    hdr_t                 hdr;
    red_op_pkg::payload_u payload;
  } flit_t;

endpackage

/* red_node_top.sv */
/*
 * Reduction stage of a mesh node
 * Arbiter and join pick one reduction stream, the combine stage folds
 * it and the credit queue sends the result downstream
 */
`timescale 1ns/1ns

module red_node_top #(
  parameter int unsigned Depth    = 4,
  parameter int unsigned Credits  = 2,
  parameter int unsigned PayloadW = 32
) (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  red_noc_pkg::xy_id_t                             xy_id_i,
  input  red_noc_pkg::flit_t [red_noc_pkg::NumRoutes-1:0] in_flit_i,
  input  logic               [red_noc_pkg::NumRoutes-1:0] in_valid_i,
  output logic               [red_noc_pkg::NumRoutes-1:0] in_ready_o,
  output red_noc_pkg::flit_t                              out_flit_o,
  output logic                                            out_valid_o,
  input  logic                                            credit_i
);

  red_noc_pkg::route_e               sel;
  logic                              join_valid;
  logic                              join_ready;
  logic [red_noc_pkg::NumRoutes-1:0] join_mask;
  red_noc_pkg::flit_t                res_flit;
  logic                              res_valid;
  logic                              res_ready;

  // Any ready marks the join handshake
  red_route_arb u_route_arb (
    .clk_i       ( clk_i        ),
    .rst_i       ( rst_i        ),
    .in_valid_i  ( in_valid_i   ),
    .join_done_i ( |in_ready_o  ),
    .sel_o       ( sel          )
  );

  red_sync u_sync (
    .sel_i        ( sel        ),
    .in_flit_i    ( in_flit_i  ),
    .in_valid_i   ( in_valid_i ),
    .in_ready_o   ( in_ready_o ),
    .xy_id_i      ( xy_id_i    ),
    .join_valid_o ( join_valid ),
    .join_ready_i ( join_ready ),
    .join_mask_o  ( join_mask  )
  );

  red_combine #(
    .PayloadW ( PayloadW )
  ) u_combine (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .in_flit_i    ( in_flit_i  ),
    .join_mask_i  ( join_mask  ),
    .sel_i        ( sel        ),
    .join_valid_i ( join_valid ),
    .join_ready_o ( join_ready ),
    .res_flit_o   ( res_flit   ),
    .res_valid_o  ( res_valid  ),
    .res_ready_i  ( res_ready  )
  );

  red_out_queue #(
    .Depth   ( Depth   ),
    .Credits ( Credits )
  ) u_out_queue (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .res_flit_i  ( res_flit    ),
    .res_valid_i ( res_valid   ),
    .res_ready_o ( res_ready   ),
    .out_flit_o  ( out_flit_o  ),
    .out_valid_o ( out_valid_o ),
    .credit_i    ( credit_i    )
  );

endmodule

/* red_op_pkg.sv */
/*
 * Reduction operation definitions
 * Encodes the operations the reduction stage can fold and the payload
 * word, which is read either as one 32-bit word or as two 16-bit lanes
 */
package red_op_pkg;

  // Payload width in bits
  parameter int unsigned PayloadW = 32;

  // Width of one lane in the paired view
  parameter int unsigned LaneW = PayloadW / 2;

  // Reduction operation carried in the flit header
  typedef enum logic [2:0] {
    OpAdd32   = 3'd0,
    OpMax32   = 3'd1,
    OpMinU32  = 3'd2,
    OpOr32    = 3'd3,
    OpAdd16x2 = 3'd4
  } op_e;

  // Lane view, hi lane in the upper half of the word
  typedef struct packed {
    logic [LaneW-1:0] hi;
    logic [LaneW-1:0] lo;
  } lanes_t;

  // Same payload bits, decoded per operation
  typedef union packed {
    logic [PayloadW-1:0] word;
    // Only OpAdd16x2 reads this view
    lanes_t              lanes;
  } payload_u;

endpackage

/* red_out_queue.sv */
/*
 * Output queue with credits
 * Buffers result flits and sends one per cycle on the output link
 * while the downstream buffer has free slots
 */
`timescale 1ns/1ns

module red_out_queue #(
  parameter int unsigned Depth   = 4,
  parameter int unsigned Credits = 2
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  red_noc_pkg::flit_t res_flit_i,
  input  logic               res_valid_i,
  output logic               res_ready_o,
  output red_noc_pkg::flit_t out_flit_o,
  output logic               out_valid_o,
  input  logic               credit_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);
  localparam int unsigned CrW  = $clog2(Credits + 1);

  red_noc_pkg::flit_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  // Free downstream slots
  logic [CrW-1:0] credit_q;

  logic push;
  logic pop;

  assign res_ready_o = count_q != CntW'(Depth);
  assign push        = res_valid_i && res_ready_o;

  // Entries written this cycle show up next cycle at the earliest
  assign out_valid_o = (count_q != '0) && (credit_q != '0);
  assign pop         = out_valid_o;
  assign out_flit_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= res_flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= CrW'(Credits);
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntW'(push) - CntW'(pop);
      // One slot used per send, one freed per returned credit
      credit_q <= credit_q - CrW'(pop) + CrW'(credit_i);
    end
  end

endmodule

/* red_route_arb.sv */
/*
 * Head route arbiter
 * Round-robin choice of the route whose header drives the next join,
 * locked until that join has been accepted
 */
`timescale 1ns/1ns

module red_route_arb (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [red_noc_pkg::NumRoutes-1:0] in_valid_i,
  input  logic                              join_done_i,
  output red_noc_pkg::route_e               sel_o
);

  // Round-robin start point
  logic [2:0] ptr_q;

  // Locked choice
  logic                lock_q;
  red_noc_pkg::route_e sel_q;

  red_noc_pkg::route_e rr_pick;
  logic [2:0]          idx;
  logic                found;

  // First valid route at or after the pointer
  always_comb begin
    rr_pick = red_noc_pkg::route_e'(ptr_q);
    found   = 1'b0;
    idx     = ptr_q;
    for (int i = 0; i < red_noc_pkg::NumRoutes; i++) begin
      idx = 3'((int'(ptr_q) + i) % red_noc_pkg::NumRoutes);
      if (!found && in_valid_i[idx]) begin
        rr_pick = red_noc_pkg::route_e'(idx);
        found   = 1'b1;
      end
    end
  end

  // Held choice wins so a later valid cannot steal the head
  assign sel_o = lock_q ? sel_q : rr_pick;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
      sel_q  <= red_noc_pkg::North;
    end else if (join_done_i) begin
      lock_q <= 1'b0;
      // Move past the served route
      if (sel_o == red_noc_pkg::Eject) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= 3'(sel_o) + 3'd1;
      end
    end else if (!lock_q && in_valid_i[sel_o]) begin
      lock_q <= 1'b1;
      sel_q  <= sel_o;
    end
  end

endmodule

/* red_route_mask.sv */
/*
 * Expected route mask
 * Works out, for the selected reduction header, which input routes
 * carry a contribution toward the root under X-first routing
 */
`timescale 1ns/1ns

module red_route_mask (
  input  red_noc_pkg::flit_t                sel_flit_i,
  input  red_noc_pkg::xy_id_t               xy_id_i,
  output logic [red_noc_pkg::NumRoutes-1:0] route_mask_o
);

  red_noc_pkg::hdr_t hdr;

  // Coordinate range spanned by the group
  logic [1:0] min_x;
  logic [1:0] max_x;
  logic [1:0] min_y;
  logic [1:0] max_y;

  logic row_member;
  logic col_member;
  logic at_dst_col;

  assign hdr = sel_flit_i.hdr;

  // Masked bits cleared give the lowest member, set give the highest
  assign min_x = hdr.grp_id.x & ~hdr.grp_mask.x;
  assign max_x = hdr.grp_id.x | hdr.grp_mask.x;
  assign min_y = hdr.grp_id.y & ~hdr.grp_mask.y;
  assign max_y = hdr.grp_id.y | hdr.grp_mask.y;

  // This node's row or column holds group members
  assign row_member = ((xy_id_i.y ^ hdr.grp_id.y) & ~hdr.grp_mask.y) == 2'b00;
  assign col_member = ((xy_id_i.x ^ hdr.grp_id.x) & ~hdr.grp_mask.x) == 2'b00;

  // Only the root column carries traffic along Y
  assign at_dst_col = xy_id_i.x == hdr.dst_id.x;

  always_comb begin
    route_mask_o = '0;
    // Members west of here in this row travel east through this node
    route_mask_o[red_noc_pkg::West] = row_member && (min_x < xy_id_i.x) &&
                                      (xy_id_i.x <= hdr.dst_id.x);
    // Mirror case for members to the east
    route_mask_o[red_noc_pkg::East] = row_member && (max_x > xy_id_i.x) &&
                                      (xy_id_i.x >= hdr.dst_id.x);
    // Rows above the node, reduced at the root column, come down from North
    route_mask_o[red_noc_pkg::North] = at_dst_col && (max_y > xy_id_i.y) &&
                                       (xy_id_i.y >= hdr.dst_id.y);
    // Rows below come up from South
    route_mask_o[red_noc_pkg::South] = at_dst_col && (min_y < xy_id_i.y) &&
                                       (xy_id_i.y <= hdr.dst_id.y);
    // Local contribution only from a member node
    route_mask_o[red_noc_pkg::Eject] = row_member && col_member;
  end

endmodule

/* red_sync.sv */
/*
 * Reduction join
 * Keeps only flits of the selected reduction stream, waits until every
 * expected route holds one and accepts them all on one cycle
 */
`timescale 1ns/1ns

module red_sync (
  input  red_noc_pkg::route_e                                   sel_i,
  input  red_noc_pkg::flit_t [red_noc_pkg::NumRoutes-1:0]       in_flit_i,
  input  logic               [red_noc_pkg::NumRoutes-1:0]       in_valid_i,
  output logic               [red_noc_pkg::NumRoutes-1:0]       in_ready_o,
  input  red_noc_pkg::xy_id_t                                   xy_id_i,
  output logic                                                  join_valid_o,
  input  logic                                                  join_ready_i,
  output logic               [red_noc_pkg::NumRoutes-1:0]       join_mask_o
);

  red_noc_pkg::flit_t sel_flit;
  logic               sel_valid;

  // Routes expected by the selected header
  logic [red_noc_pkg::NumRoutes-1:0] route_mask;

  // Valid flits that belong to the selected stream
  logic [red_noc_pkg::NumRoutes-1:0] match;

  logic join_fire;

  assign sel_flit  = in_flit_i[sel_i];
  assign sel_valid = in_valid_i[sel_i];

  red_route_mask u_route_mask (
    .sel_flit_i   ( sel_flit   ),
    .xy_id_i      ( xy_id_i    ),
    .route_mask_o ( route_mask )
  );

  // Stream identity is root, group base and group mask
  for (genvar r = 0; r < red_noc_pkg::NumRoutes; r++) begin : gen_match
    assign match[r] = in_valid_i[r] &&
                      (in_flit_i[r].hdr.dst_id == sel_flit.hdr.dst_id) &&
                      (in_flit_i[r].hdr.grp_id == sel_flit.hdr.grp_id) &&
                      (in_flit_i[r].hdr.grp_mask == sel_flit.hdr.grp_mask);
  end

  // Nothing is expected while the selected route is idle
  assign join_mask_o = route_mask & {red_noc_pkg::NumRoutes{sel_valid}};

  // All expected routes present, none missing
  assign join_valid_o = (|join_mask_o) && ((join_mask_o & ~match) == '0);

  assign join_fire = join_valid_o && join_ready_i;

  // Expected routes are released together, others stay blocked
  assign in_ready_o = join_mask_o & {red_noc_pkg::NumRoutes{join_fire}};

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the reduction stage testbench with Verilator and run it
verilator --binary --timing --assert -f files.f --top-module tb_red_node \
  && ./obj_dir/Vtb_red_node \
  || exit 1

/* tb_clk_gen.sv */
/*
 * Testbench clock source
 * Free-running clock with a 10 ns period
 */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o
);

  // Half period of 5 ns
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

endmodule

/* tb_red_node.sv */
/*
 * Testbench of the reduction stage
 * Feeds batches of reductions on the five input routes, predicts every
 * joined result from the membership and XY routing rules, returns output
 * credits after random delays and checks the DUT with assertions
 */
`timescale 1ns/1ns

module tb_red_node;

  localparam int unsigned Credits    = 2;
  // Up to three reductions with disjoint route sets per batch
  localparam int unsigned NumBatches = 120;
  // Twice the longest run at five cycles of credit delay
  localparam int unsigned MaxCycles  = 4000;
  localparam red_noc_pkg::xy_id_t NodeId = '{x: 2'd1, y: 2'd2};

  logic clk;
  logic rst = 1'b1;
  red_noc_pkg::flit_t [red_noc_pkg::NumRoutes-1:0] in_flit = '0;
  logic [red_noc_pkg::NumRoutes-1:0] in_valid = '0;
  logic [red_noc_pkg::NumRoutes-1:0] in_ready;
  red_noc_pkg::flit_t out_flit;
  logic out_valid;
  logic credit = 1'b0;

  // Per-route flits not yet driven, predicted results, credit due times
  red_noc_pkg::flit_t pend_q [red_noc_pkg::NumRoutes][$];
  red_noc_pkg::flit_t exp_q [$];
  int unsigned due_q [$];

  int unsigned cycle = 0;
  int unsigned gen_cnt = 0;
  int unsigned join_cnt = 0;
  int unsigned send_cnt = 0;
  int unsigned cred_cnt = 0;
  int unsigned owed = 0;
  int unsigned wait_cnt [red_noc_pkg::NumRoutes] = '{default: 0};

  tb_clk_gen u_clk_gen (
    .clk_o ( clk )
  );

  red_node_top #(
    .Depth    ( 4                   ),
    .Credits  ( Credits             ),
    .PayloadW ( red_op_pkg::PayloadW )
  ) uut (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .xy_id_i     ( NodeId    ),
    .in_flit_i   ( in_flit   ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .out_flit_o  ( out_flit  ),
    .out_valid_o ( out_valid ),
    .credit_i    ( credit    )
  );

  task automatic report_error(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Member when all unmasked bits agree with the group base
  function automatic logic in_group(input int mx, input int my, input red_noc_pkg::hdr_t h);
    return (((mx ^ int'(h.grp_id.x)) & ~int'(h.grp_mask.x) & 3) == 0) &&
           (((my ^ int'(h.grp_id.y)) & ~int'(h.grp_mask.y) & 3) == 0);
  endfunction

  // Walk each member's X-first path to the root and note where it enters here
  function automatic logic [red_noc_pkg::NumRoutes-1:0] expected_routes(
    input red_noc_pkg::hdr_t h
  );
    logic [red_noc_pkg::NumRoutes-1:0] routes;
    int dx;
    int dy;
    int cx;
    int cy;
    int px;
    int py;
    routes = '0;
    dx = int'(h.dst_id.x);
    dy = int'(h.dst_id.y);
    for (int mx = 0; mx < 4; mx++) begin
      for (int my = 0; my < 4; my++) begin
        if (in_group(mx, my, h)) begin
          cx = mx;
          cy = my;
          if (cx == int'(NodeId.x) && cy == int'(NodeId.y)) begin
            routes[red_noc_pkg::Eject] = 1'b1;
          end
          while (cx != dx || cy != dy) begin
            px = cx;
            py = cy;
            if (cx != dx) begin
              cx = (dx > cx) ? cx + 1 : cx - 1;
            end else begin
              cy = (dy > cy) ? cy + 1 : cy - 1;
            end
            if (cx == int'(NodeId.x) && cy == int'(NodeId.y)) begin
              // North neighbour sits at y + 1
              if (cx > px) routes[red_noc_pkg::West] = 1'b1;
              else if (cx < px) routes[red_noc_pkg::East] = 1'b1;
              else if (cy > py) routes[red_noc_pkg::South] = 1'b1;
              else routes[red_noc_pkg::North] = 1'b1;
            end
          end
        end
      end
    end
    return routes;
  endfunction

  // Fold starts from the first joined payload, no neutral value needed
  function automatic red_op_pkg::payload_u fold_payloads(
    input red_op_pkg::op_e                                 op,
    input logic [red_noc_pkg::NumRoutes-1:0]               routes,
    input red_noc_pkg::flit_t [red_noc_pkg::NumRoutes-1:0] flits
  );
    red_op_pkg::payload_u res;
    logic [31:0] acc;
    logic [31:0] v;
    logic [15:0] hi;
    logic [15:0] lo;
    logic        seen;
    acc  = '0;
    seen = 1'b0;
    for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
      if (routes[r]) begin
        v = flits[r].payload.word;
        if (!seen) begin
          acc = v;
        end else begin
          case (op)
            red_op_pkg::OpAdd32:  acc = acc + v;
            red_op_pkg::OpMax32:  acc = ($signed(v) > $signed(acc)) ? v : acc;
            red_op_pkg::OpMinU32: acc = (v < acc) ? v : acc;
            red_op_pkg::OpOr32:   acc = acc | v;
            // Two 16-bit sums, carry dropped at each lane top
            red_op_pkg::OpAdd16x2: begin
              hi  = acc[31:16] + v[31:16];
              lo  = acc[15:0] + v[15:0];
              acc = {hi, lo};
            end
            default: acc = acc;
          endcase
        end
        seen = 1'b1;
      end
    end
    res.word = acc;
    return res;
  endfunction

  function automatic logic same_stream(input red_noc_pkg::hdr_t a, input red_noc_pkg::hdr_t b);
    return a.dst_id == b.dst_id && a.grp_id == b.grp_id && a.grp_mask == b.grp_mask;
  endfunction

  function automatic logic sources_idle();
    logic idle;
    idle = in_valid == '0;
    for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
      if (pend_q[r].size() != 0) idle = 1'b0;
    end
    return idle;
  endfunction

  // Each route holds its head flit until the DUT takes it, also in reset
  always @(posedge clk) begin
    red_noc_pkg::flit_t next_flit;
    for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
      if (!in_valid[r] || in_ready[r]) begin
        if (pend_q[r].size() != 0) begin
          next_flit = pend_q[r].pop_front();
          in_flit[r]  <= next_flit;
          in_valid[r] <= 1'b1;
        end else begin
          in_valid[r] <= 1'b0;
        end
      end
    end
  end

  // Join prediction, result compare and fairness count
  always @(posedge clk) begin
    logic [red_noc_pkg::NumRoutes-1:0] exp_routes;
    red_noc_pkg::flit_t                res;
    int                                lead;
    if (!rst && in_ready != '0) begin
      lead = 0;
      for (int r = int'(red_noc_pkg::NumRoutes) - 1; r >= 0; r--) begin
        if (in_ready[r]) lead = r;
      end
      exp_routes = expected_routes(in_flit[lead].hdr);
      assert (in_ready == exp_routes)
        else report_error($sformatf("mismatch at %0t ns: ready %b, expected routes %b",
                                    $time, in_ready, exp_routes));
      for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
        assert (!exp_routes[r] || (in_valid[r] && same_stream(in_flit[r].hdr, in_flit[lead].hdr)))
          else report_error($sformatf("mismatch at %0t ns: route %0d joined without a flit",
                                      $time, r));
      end
      res.hdr     = in_flit[lead].hdr;
      res.payload = fold_payloads(in_flit[lead].hdr.op, exp_routes, in_flit);
      exp_q.push_back(res);
      join_cnt++;
    end
    for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
      if (!in_valid[r] || in_ready[r]) wait_cnt[r] = 0;
      else if (in_ready != '0) wait_cnt[r]++;
      assert (wait_cnt[r] <= red_noc_pkg::NumRoutes)
        else report_error($sformatf("route %0d starved over %0d joins", r, wait_cnt[r]));
    end
    if (!rst && out_valid) begin
      assert (exp_q.size() != 0)
        else report_error("output flit sent with no completed join left to match");
      if (exp_q.size() != 0) begin
        assert (out_flit == exp_q[0])
          else report_error($sformatf("mismatch at %0t ns: out flit %h, expected %h",
                                      $time, out_flit, exp_q[0]));
        void'(exp_q.pop_front());
      end
    end
  end

  // Downstream buffer frees one slot 0 to 5 cycles after each flit
  always @(posedge clk) begin
    if (rst) begin
      credit <= 1'b0;
    end else begin
      if (out_valid) begin
        due_q.push_back(cycle + $urandom_range(0, 5));
        send_cnt <= send_cnt + 1;
      end
      if (credit) cred_cnt <= cred_cnt + 1;
      for (int i = int'(due_q.size()) - 1; i >= 0; i--) begin
        if (due_q[i] <= cycle) begin
          owed++;
          due_q.delete(i);
        end
      end
      // One credit pulse per cycle at most
      if (owed != 0) begin
        credit <= 1'b1;
        owed--;
      end else begin
        credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == MaxCycles) begin
      report_error($sformatf("timeout, run still busy after %0d cycles", MaxCycles));
    end
  end

  // Quiet outputs in reset and on the first cycle after it
  assert property (@(posedge clk) (cycle != 0) && (rst || $past(rst)) |->
                   (!out_valid && in_ready == '0))
    else report_error($sformatf("mismatch at %0t ns: output active around reset", $time));

  // Never more sends than initial credits plus returned ones
  assert property (@(posedge clk) disable iff (rst) out_valid |-> (send_cnt < Credits + cred_cnt))
    else report_error($sformatf("mismatch at %0t ns: send %0d beyond %0d credits",
                                $time, send_cnt + 1, Credits + cred_cnt));

  // Reset for 16 cycles while the first flits already wait on the routes
  initial begin
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  initial begin
    logic [red_noc_pkg::NumRoutes-1:0] used;
    logic [red_noc_pkg::NumRoutes-1:0] routes;
    red_noc_pkg::hdr_t                 h;
    red_noc_pkg::flit_t                f;
    void'($urandom(32'had3a));
    for (int b = 0; b < NumBatches; b++) begin
      @(negedge clk);
      used = '0;
      // First batch always holds a stream so valid flits meet the reset
      for (int a = 0; a < 3 || gen_cnt == 0; a++) begin
        h.dst_id   = 4'($urandom_range(0, 15));
        h.grp_id   = 4'($urandom_range(0, 15));
        h.grp_mask = 4'($urandom_range(0, 15));
        h.op       = red_op_pkg::op_e'(3'($urandom_range(0, 4)));
        routes     = expected_routes(h);
        // Disjoint sets keep concurrent streams from blocking each other
        if (routes != '0 && (routes & used) == '0) begin
          used |= routes;
          gen_cnt++;
          for (int r = 0; r < red_noc_pkg::NumRoutes; r++) begin
            if (routes[r]) begin
              f.hdr          = h;
              f.payload.word = $urandom();
              pend_q[r].push_back(f);
            end
          end
        end
      end
      while (!sources_idle()) @(negedge clk);
    end
    while (exp_q.size() != 0) @(negedge clk);
    // Extra cycles catch a duplicated result
    repeat (20) @(negedge clk);
    if (gen_cnt == join_cnt && join_cnt == send_cnt) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_error($sformatf("mismatch at %0t ns: %0d reductions, %0d joins, %0d sent",
                             $time, gen_cnt, join_cnt, send_cnt));
    end
  end

endmodule
